//--- Makefile
VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = dcache_tb
FILELIST  = dcache_top.f
OBJ_DIR   = obj_dir
PASS_MSG  = Testbench passed

.PHONY: lint build sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the run passes only when the pass line shows up in the output
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- dcache_top.f
src/dcache_pkg.sv
src/dcache_way_if.sv
src/dcache_way_store.sv
src/dcache_replace.sv
src/dcache_ctrl.sv
src/dcache_top.sv
verification/dcache_mem_model.sv
verification/dcache_tb.sv

//--- src/dcache_ctrl.sv
module dcache_ctrl
    import dcache_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        cpu_rreq_i,
    input  logic        cpu_wreq_i,
    input  addr_t       cpu_addr_i,
    input  word_t       cpu_wdata_i,
    input  wsel_t       cpu_wsel_i,
    output logic        cpu_stall_o,
    output logic        cpu_data_valid_o,
    output word_t       cpu_data_o,
    output logic        mem_ren_o,
    output addr_t       mem_araddr_o,
    input  logic        mem_rvalid_i,
    input  line_t       mem_rdata_i,
    output logic        mem_wen_o,
    output addr_t       mem_awaddr_o,
    output line_t       mem_wdata_o,
    input  logic        mem_bvalid_i,
    dcache_way_if.ctrl  way0,
    dcache_way_if.ctrl  way1,
    output index_t      index_o,
    output logic        touch_o,
    output logic        touch_way_o,
    output logic        fill_o,
    output logic        fill_dirty_o,
    input  logic        victim_way_i,
    input  logic        victim_dirty_i
);

    ctrl_state_t state_q, state_d;

    logic  req_rd_q, req_wr_q;
    addr_t req_addr_q;
    word_t req_wdata_q;
    wsel_t req_wsel_q;

    logic    hit0, hit1, hit, miss, fill;
    tag_t    req_tag;
    index_t  req_index;
    offset_t req_off;
    line_t   hit_line, base_line, new_line;
    word_t   old_word, wmask;

    ////////////////////////////////////////
    // lookup stage register
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            req_rd_q <= 1'b0;
            req_wr_q <= 1'b0;
        end else if (!cpu_stall_o) begin
            req_rd_q <= cpu_rreq_i;
            req_wr_q <= cpu_wreq_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!cpu_stall_o) begin
            req_addr_q  <= cpu_addr_i;
            req_wdata_q <= cpu_wdata_i;
            req_wsel_q  <= cpu_wsel_i;
        end
    end

    assign req_tag   = addr_tag(req_addr_q);
    assign req_index = addr_index(req_addr_q);
    assign req_off   = addr_offset(req_addr_q);

    // keep reading the held set while stalled
    assign way0.rd_index = cpu_stall_o ? req_index : addr_index(cpu_addr_i);
    assign way1.rd_index = cpu_stall_o ? req_index : addr_index(cpu_addr_i);

    ////////////////////////////////////////
    // hit and merge
    ////////////////////////////////////////

    assign hit0 = way0.rd_valid && (way0.rd_tag == req_tag);
    assign hit1 = way1.rd_valid && (way1.rd_tag == req_tag);
    assign hit  = (state_q == ST_LOOKUP) && (req_rd_q || req_wr_q) && (hit0 || hit1);
    assign miss = (state_q == ST_LOOKUP) && (req_rd_q || req_wr_q) && !(hit0 || hit1);
    assign fill = (state_q == ST_REFILL) && mem_rvalid_i;

    assign hit_line  = hit1 ? way1.rd_line : way0.rd_line;
    assign base_line = (state_q == ST_REFILL) ? mem_rdata_i : hit_line;
    assign old_word  = base_line[req_off*WORD_W +: WORD_W];
    assign wmask     = {{8{req_wsel_q[3]}}, {8{req_wsel_q[2]}},
                        {8{req_wsel_q[1]}}, {8{req_wsel_q[0]}}};

    always_comb begin
        new_line = base_line;
        if (req_wr_q) begin
            new_line[req_off*WORD_W +: WORD_W] = (req_wdata_q & wmask) | (old_word & ~wmask);
        end
    end

    assign way0.wr_en    = (hit && hit0 && req_wr_q) || (fill && !victim_way_i);
    assign way1.wr_en    = (hit && hit1 && req_wr_q) || (fill && victim_way_i);
    assign way0.wr_index = req_index;
    assign way1.wr_index = req_index;
    assign way0.wr_tag   = req_tag;
    assign way1.wr_tag   = req_tag;
    assign way0.wr_line  = new_line;
    assign way1.wr_line  = new_line;

    assign index_o      = req_index;
    assign touch_o      = hit;
    assign touch_way_o  = hit1;
    assign fill_o       = fill;
    assign fill_dirty_o = req_wr_q;

    ////////////////////////////////////////
    // miss FSM
    ////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_LOOKUP:    if (miss) state_d = victim_dirty_i ? ST_WRITEBACK : ST_REFILL;
            ST_WRITEBACK: if (mem_bvalid_i) state_d = ST_REFILL;
            ST_REFILL:    if (mem_rvalid_i) state_d = ST_LOOKUP;
            default:      state_d = ST_LOOKUP;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ST_LOOKUP;
        end else begin
            state_q <= state_d;
        end
    end

    assign cpu_stall_o = miss || (state_q == ST_WRITEBACK)
                         || ((state_q == ST_REFILL) && !mem_rvalid_i);

    // victim line stays on the way outputs while the set is held
    assign mem_wen_o    = (state_q == ST_WRITEBACK);
    assign mem_awaddr_o = line_addr(victim_way_i ? way1.rd_tag : way0.rd_tag, req_index);
    assign mem_wdata_o  = victim_way_i ? way1.rd_line : way0.rd_line;
    assign mem_ren_o    = (state_q == ST_REFILL);
    assign mem_araddr_o = line_addr(req_tag, req_index);

    assign cpu_data_valid_o = req_rd_q && (hit || fill);
    assign cpu_data_o       = base_line[req_off*WORD_W +: WORD_W];

    a_one_hit: assert property (@(posedge clk) disable iff (rst) !(hit0 && hit1));
    a_valid_read: assert property (@(posedge clk) disable iff (rst)
        cpu_data_valid_o |-> !req_wr_q);

endmodule

//--- src/dcache_pkg.sv
package dcache_pkg;

    ////////////////////////////////////////
    // geometry
    ////////////////////////////////////////

    localparam int unsigned WORD_W         = 32;
    localparam int unsigned WORDS_PER_LINE = 8;
    localparam int unsigned NUM_SETS       = 128;
    localparam int unsigned INDEX_W        = 7;
    localparam int unsigned OFFSET_W       = 3;
    localparam int unsigned TAG_W          = 20;

    typedef logic [31:0]                      addr_t;
    typedef logic [WORD_W-1:0]                word_t;
    typedef logic [3:0]                       wsel_t;
    typedef logic [TAG_W-1:0]                 tag_t;
    typedef logic [INDEX_W-1:0]               index_t;
    typedef logic [OFFSET_W-1:0]              offset_t;
    // word 0 sits in the low bits, same order as memory
    typedef logic [WORDS_PER_LINE*WORD_W-1:0] line_t;

    typedef enum logic [1:0] {
        ST_LOOKUP,
        ST_WRITEBACK,
        ST_REFILL
    } ctrl_state_t;

    // address fields
    function automatic tag_t addr_tag(input addr_t addr);
        return addr[31:12];
    endfunction

    function automatic index_t addr_index(input addr_t addr);
        return addr[11:5];
    endfunction

    function automatic offset_t addr_offset(input addr_t addr);
        return addr[4:2];
    endfunction

    function automatic addr_t line_addr(input tag_t tag, input index_t index);
        return {tag, index, 5'b0};
    endfunction

endpackage

//--- src/dcache_replace.sv
module dcache_replace
    import dcache_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  index_t index_i,
    input  logic   touch_i,
    input  logic   touch_way_i,
    input  logic   fill_i,
    // the access is a write, used by touch and fill alike
    input  logic   fill_dirty_i,
    output logic   victim_way_o,
    output logic   victim_dirty_o
);

    // lru bit names the way to evict next
    logic [NUM_SETS-1:0]      lru_q;
    logic [NUM_SETS-1:0][1:0] dirty_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            lru_q   <= '0;
            dirty_q <= '0;
        end else if (touch_i) begin
            lru_q[index_i] <= ~touch_way_i;
            if (fill_dirty_i) begin
                dirty_q[index_i][touch_way_i] <= 1'b1;
            end
        end else if (fill_i) begin
            // new line becomes most recent
            lru_q[index_i]                     <= ~lru_q[index_i];
            dirty_q[index_i][lru_q[index_i]] <= fill_dirty_i;
        end
    end

    assign victim_way_o   = lru_q[index_i];
    assign victim_dirty_o = dirty_q[index_i][lru_q[index_i]];

endmodule

//--- src/dcache_top.sv
module dcache_top
    import dcache_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  cpu_rreq_i,
    input  logic  cpu_wreq_i,
    input  addr_t cpu_addr_i,
    input  word_t cpu_wdata_i,
    input  wsel_t cpu_wsel_i,
    output logic  cpu_stall_o,
    output logic  cpu_data_valid_o,
    output word_t cpu_data_o,
    output logic  mem_ren_o,
    output addr_t mem_araddr_o,
    input  logic  mem_rvalid_i,
    input  line_t mem_rdata_i,
    output logic  mem_wen_o,
    output addr_t mem_awaddr_o,
    output line_t mem_wdata_o,
    input  logic  mem_bvalid_i
);

    dcache_way_if way0_if ();
    dcache_way_if way1_if ();

    // replacement state wires
    index_t repl_index;
    logic   repl_touch, repl_touch_way, repl_fill, repl_fill_dirty;
    logic   victim_way, victim_dirty;

    dcache_ctrl u_ctrl (
        .clk              (clk),
        .rst              (rst),
        .cpu_rreq_i       (cpu_rreq_i),
        .cpu_wreq_i       (cpu_wreq_i),
        .cpu_addr_i       (cpu_addr_i),
        .cpu_wdata_i      (cpu_wdata_i),
        .cpu_wsel_i       (cpu_wsel_i),
        .cpu_stall_o      (cpu_stall_o),
        .cpu_data_valid_o (cpu_data_valid_o),
        .cpu_data_o       (cpu_data_o),
        .mem_ren_o        (mem_ren_o),
        .mem_araddr_o     (mem_araddr_o),
        .mem_rvalid_i     (mem_rvalid_i),
        .mem_rdata_i      (mem_rdata_i),
        .mem_wen_o        (mem_wen_o),
        .mem_awaddr_o     (mem_awaddr_o),
        .mem_wdata_o      (mem_wdata_o),
        .mem_bvalid_i     (mem_bvalid_i),
        .way0             (way0_if.ctrl),
        .way1             (way1_if.ctrl),
        .index_o          (repl_index),
        .touch_o          (repl_touch),
        .touch_way_o      (repl_touch_way),
        .fill_o           (repl_fill),
        .fill_dirty_o     (repl_fill_dirty),
        .victim_way_i     (victim_way),
        .victim_dirty_i   (victim_dirty)
    );

    dcache_way_store way0 (.clk(clk), .rst(rst), .way(way0_if.store));
    dcache_way_store way1 (.clk(clk), .rst(rst), .way(way1_if.store));

    dcache_replace u_replace (
        .clk            (clk),
        .rst            (rst),
        .index_i        (repl_index),
        .touch_i        (repl_touch),
        .touch_way_i    (repl_touch_way),
        .fill_i         (repl_fill),
        .fill_dirty_i   (repl_fill_dirty),
        .victim_way_o   (victim_way),
        .victim_dirty_o (victim_dirty)
    );

endmodule

//--- src/dcache_way_if.sv
interface dcache_way_if
    import dcache_pkg::*;
();

    // read port, data comes back one cycle later
    index_t rd_index;
    logic   rd_valid;
    tag_t   rd_tag;
    line_t  rd_line;

    // write port, always a whole line
    logic   wr_en;
    index_t wr_index;
    tag_t   wr_tag;
    line_t  wr_line;

    modport ctrl (
        output rd_index, wr_en, wr_index, wr_tag, wr_line,
        input  rd_valid, rd_tag, rd_line
    );

    modport store (
        input  rd_index, wr_en, wr_index, wr_tag, wr_line,
        output rd_valid, rd_tag, rd_line
    );

endinterface

//--- src/dcache_way_store.sv
module dcache_way_store
    import dcache_pkg::*;
(
    input logic         clk,
    input logic         rst,
    dcache_way_if.store way
);

    line_t               data_mem [NUM_SETS];
    tag_t                tag_mem  [NUM_SETS];
    logic [NUM_SETS-1:0] valid_q;

    line_t rd_line_q;
    tag_t  rd_tag_q;
    logic  rd_valid_q;

    // registered copy of a write that hits the set being read
    logic  bypass_q;
    line_t byp_line_q;
    tag_t  byp_tag_q;

    ////////////////////////////////////////
    // arrays
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (way.wr_en) begin
            data_mem[way.wr_index] <= way.wr_line;
            tag_mem[way.wr_index]  <= way.wr_tag;
        end
        rd_line_q  <= data_mem[way.rd_index];
        rd_tag_q   <= tag_mem[way.rd_index];
        byp_line_q <= way.wr_line;
        byp_tag_q  <= way.wr_tag;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q    <= '0;
            rd_valid_q <= 1'b0;
            bypass_q   <= 1'b0;
        end else begin
            if (way.wr_en) begin
                valid_q[way.wr_index] <= 1'b1;
            end
            rd_valid_q <= valid_q[way.rd_index];
            // array read sees the old line at this edge
            bypass_q   <= way.wr_en && (way.wr_index == way.rd_index);
        end
    end

    ////////////////////////////////////////
    // read data with collision forwarding
    ////////////////////////////////////////

    assign way.rd_valid = bypass_q | rd_valid_q;
    assign way.rd_tag   = bypass_q ? byp_tag_q  : rd_tag_q;
    assign way.rd_line  = bypass_q ? byp_line_q : rd_line_q;

    // a written set reads back valid from the array itself
    a_write_reads_valid: assert property (
        @(posedge clk) disable iff (rst)
        $past(way.wr_en) && (way.rd_index == $past(way.wr_index)) |=> rd_valid_q
    );

endmodule

//--- verification/dcache_mem_model.sv
module dcache_mem_model
    import dcache_pkg::*;
#(
    parameter int          MEM_WORDS = 4096,
    parameter word_t       FILL_KEY  = 32'h0,
    parameter int          LAT_MIN   = 1,
    parameter int          LAT_MAX   = 4,
    parameter logic [15:0] SEED      = 16'd13253
) (
    input  logic  clk,
    input  logic  ren_i,
    input  addr_t araddr_i,
    output logic  rvalid_o,
    output line_t rdata_o,
    input  logic  wen_i,
    input  addr_t awaddr_i,
    input  line_t wdata_i,
    output logic  bvalid_o
);

    word_t       mem [MEM_WORDS];
    logic [15:0] lfsr = SEED;
    logic [1:0]  lat_bits;
    logic        busy = 1'b0;
    int          wait_cnt = 0;

    // taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    initial begin
        rvalid_o = 1'b0;
        bvalid_o = 1'b0;
        rdata_o  = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = word_t'(i * 4) ^ FILL_KEY;
        end
        forever begin
            @(posedge clk);
            #1;
            rvalid_o = 1'b0;
            bvalid_o = 1'b0;
            if (!(ren_i || wen_i)) begin
                busy = 1'b0;
            end else if (!busy) begin
                // one lfsr step per latency bit
                busy        = 1'b1;
                lfsr        = lfsr_step(lfsr);
                lat_bits[0] = lfsr[0];
                lfsr        = lfsr_step(lfsr);
                lat_bits[1] = lfsr[0];
                wait_cnt    = LAT_MIN + int'(lat_bits) % (LAT_MAX - LAT_MIN + 1);
            end else if (wait_cnt > 1) begin
                wait_cnt = wait_cnt - 1;
            end else begin
                busy = 1'b0;
                if (wen_i) begin
                    for (int w = 0; w < WORDS_PER_LINE; w++) begin
                        mem[{awaddr_i[13:5], 3'(w)}] = wdata_i[w*WORD_W +: WORD_W];
                    end
                    bvalid_o = 1'b1;
                end else begin
                    for (int w = 0; w < WORDS_PER_LINE; w++) begin
                        rdata_o[w*WORD_W +: WORD_W] = mem[{araddr_i[13:5], 3'(w)}];
                    end
                    rvalid_o = 1'b1;
                end
            end
        end
    end

endmodule

//--- verification/dcache_tb.sv
module dcache_tb
    import dcache_pkg::*;
();

    localparam int         MEM_WORDS   = 4096;
    localparam word_t      FILL_KEY    = 32'h5a3c_96e1;
    localparam int         NUM_REQ     = 37;
    localparam int         CYCLE_LIMIT = 40 * NUM_REQ;
    localparam logic [1:0] EXP_ANY     = 2'd0;
    localparam logic [1:0] EXP_HIT     = 2'd1;
    localparam logic [1:0] EXP_MISS    = 2'd2;
    localparam logic [1:0] EXP_WB      = 2'd3;

    logic  clk = 1'b0;
    logic  rst;
    logic  cpu_rreq, cpu_wreq, cpu_stall, cpu_data_valid;
    addr_t cpu_addr;
    word_t cpu_wdata, cpu_data;
    wsel_t cpu_wsel;
    logic  mem_ren, mem_rvalid, mem_wen, mem_bvalid;
    addr_t mem_araddr, mem_awaddr;
    line_t mem_rdata, mem_wdata;

    // request in the lookup stage as seen from the cpu side
    logic       captured, lk_busy, lk_rd, ren_seen, wb_seen;
    addr_t      lk_addr;
    logic [1:0] req_exp, lk_exp;
    addr_t      req_wb_addr, lk_wb_addr;
    word_t      shadow [MEM_WORDS];
    word_t      exp_word;
    addr_t      exp_raddr;
    line_t      exp_wline;
    int         cycle_count = 0;

    always #2 clk = ~clk;

    dcache_top UUT (
        .clk(clk), .rst(rst),
        .cpu_rreq_i(cpu_rreq), .cpu_wreq_i(cpu_wreq), .cpu_addr_i(cpu_addr),
        .cpu_wdata_i(cpu_wdata), .cpu_wsel_i(cpu_wsel),
        .cpu_stall_o(cpu_stall), .cpu_data_valid_o(cpu_data_valid), .cpu_data_o(cpu_data),
        .mem_ren_o(mem_ren), .mem_araddr_o(mem_araddr),
        .mem_rvalid_i(mem_rvalid), .mem_rdata_i(mem_rdata),
        .mem_wen_o(mem_wen), .mem_awaddr_o(mem_awaddr), .mem_wdata_o(mem_wdata),
        .mem_bvalid_i(mem_bvalid)
    );

    dcache_mem_model #(.MEM_WORDS(MEM_WORDS), .FILL_KEY(FILL_KEY)) u_mem (
        .clk(clk),
        .ren_i(mem_ren), .araddr_i(mem_araddr), .rvalid_o(mem_rvalid), .rdata_o(mem_rdata),
        .wen_i(mem_wen), .awaddr_i(mem_awaddr), .wdata_i(mem_wdata), .bvalid_o(mem_bvalid)
    );

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1);
    endtask

    function automatic word_t merge_bytes(input word_t old_word, input word_t new_word,
                                          input wsel_t sel);
        word_t result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                result[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return result;
    endfunction

    function automatic addr_t make_addr(input int tag, input int index, input int off);
        return {tag_t'(tag), index_t'(index), offset_t'(off), 2'b00};
    endfunction

    // hold the request until a clock edge with stall low takes it
    task automatic issue_request(input logic rd, input addr_t addr, input word_t data,
                                 input wsel_t sel, input logic [1:0] exp_code,
                                 input addr_t wb_addr);
        cpu_rreq    = rd;
        cpu_wreq    = !rd;
        cpu_addr    = addr;
        cpu_wdata   = data;
        cpu_wsel    = sel;
        req_exp     = exp_code;
        req_wb_addr = wb_addr;
        do @(negedge clk); while (cpu_stall);
        @(posedge clk);
        #1;
        cpu_rreq = 1'b0;
        cpu_wreq = 1'b0;
        req_exp  = EXP_ANY;
    endtask

    task automatic wait_idle();
        do @(negedge clk); while (lk_busy || cpu_stall);
    endtask

    ////////////////////////////////////////
    // shadow memory and lookup tracking
    ////////////////////////////////////////

    assign captured = !cpu_stall && (cpu_rreq || cpu_wreq);

    always @(posedge clk) begin
        if (rst) begin
            lk_busy  <= 1'b0;
            lk_rd    <= 1'b0;
            lk_exp   <= EXP_ANY;
            ren_seen <= 1'b0;
            wb_seen  <= 1'b0;
            for (int i = 0; i < MEM_WORDS; i++) begin
                shadow[i] <= word_t'(i * 4) ^ FILL_KEY;
            end
        end else if (!cpu_stall) begin
            lk_busy    <= cpu_rreq || cpu_wreq;
            lk_rd      <= cpu_rreq;
            lk_addr    <= cpu_addr;
            lk_exp     <= req_exp;
            lk_wb_addr <= req_wb_addr;
            ren_seen   <= 1'b0;
            wb_seen    <= 1'b0;
            if (cpu_wreq) begin
                shadow[cpu_addr[13:2]] <= merge_bytes(shadow[cpu_addr[13:2]], cpu_wdata,
                                                      cpu_wsel);
            end
        end else begin
            ren_seen <= ren_seen || mem_ren;
            wb_seen  <= wb_seen || mem_wen;
        end
    end

    always_comb begin
        exp_word  = shadow[lk_addr[13:2]];
        exp_raddr = {lk_addr[31:5], 5'b0};
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            exp_wline[w*WORD_W +: WORD_W] = shadow[{lk_wb_addr[13:5], offset_t'(w)}];
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == CYCLE_LIMIT) begin
            report_failure($sformatf("timeout, requests did not finish in %0d cycles",
                                     CYCLE_LIMIT));
        end
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    a_reset_idle: assert property (@(posedge clk)
        rst |=> !cpu_stall && !cpu_data_valid && !mem_ren && !mem_wen)
        else report_failure("stall, data valid or a memory enable is high after reset");

    a_read_data: assert property (@(posedge clk) disable iff (rst)
        cpu_data_valid |-> lk_rd && cpu_data == exp_word)
        else report_failure($sformatf("[ERROR] cpu_data_o: got %h, expected %h at %h",
            $sampled(cpu_data), $sampled(exp_word), $sampled(lk_addr)));

    a_read_done: assert property (@(posedge clk) disable iff (rst)
        lk_busy && lk_rd && !cpu_stall |-> cpu_data_valid)
        else report_failure("a read left lookup without data valid");

    a_hit_timing: assert property (@(posedge clk) disable iff (rst)
        captured && req_exp == EXP_HIT |=> !cpu_stall)
        else report_failure("an expected hit stalled the cpu");

    a_miss_stall: assert property (@(posedge clk) disable iff (rst)
        captured && (req_exp == EXP_MISS || req_exp == EXP_WB) |=> cpu_stall)
        else report_failure("an expected miss did not stall the cpu");

    a_mem_traffic: assert property (@(posedge clk) disable iff (rst)
        lk_busy && !cpu_stall && lk_exp != EXP_ANY
        |-> ren_seen == (lk_exp != EXP_HIT) && wb_seen == (lk_exp == EXP_WB))
        else report_failure($sformatf("memory traffic of request at %h is not as expected",
            $sampled(lk_addr)));

    a_refill_addr: assert property (@(posedge clk) disable iff (rst)
        mem_ren |-> mem_araddr == exp_raddr)
        else report_failure($sformatf("[ERROR] mem_araddr_o: got %h, expected %h",
            $sampled(mem_araddr), $sampled(exp_raddr)));

    a_wb_addr: assert property (@(posedge clk) disable iff (rst)
        mem_wen |-> mem_awaddr == lk_wb_addr)
        else report_failure($sformatf("[ERROR] mem_awaddr_o: got %h, expected %h",
            $sampled(mem_awaddr), $sampled(lk_wb_addr)));

    a_wb_data: assert property (@(posedge clk) disable iff (rst)
        mem_wen |-> mem_wdata == exp_wline)
        else report_failure($sformatf("[ERROR] mem_wdata_o: got %h, expected %h",
            $sampled(mem_wdata), $sampled(exp_wline)));

    a_ren_hold: assert property (@(posedge clk) disable iff (rst)
        mem_ren && !mem_rvalid |=> mem_ren && $stable(mem_araddr))
        else report_failure("mem_ren_o or its address changed before rvalid");

    a_wen_hold: assert property (@(posedge clk) disable iff (rst)
        mem_wen && !mem_bvalid |=> mem_wen && $stable(mem_awaddr))
        else report_failure("mem_wen_o or its address changed before bvalid");

    a_one_enable: assert property (@(posedge clk) disable iff (rst)
        !(mem_ren && mem_wen))
        else report_failure("memory read and write enables are high together");

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    initial begin
        rst         = 1'b1;
        cpu_rreq    = 1'b0;
        cpu_wreq    = 1'b0;
        cpu_addr    = '0;
        cpu_wdata   = '0;
        cpu_wsel    = '0;
        req_exp     = EXP_ANY;
        req_wb_addr = '0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        // tags 0, 1 and 2 share set 5
        issue_request(1'b1, make_addr(0, 5, 1), '0, '0, EXP_MISS, '0);
        issue_request(1'b1, make_addr(0, 5, 3), '0, '0, EXP_HIT, '0);
        issue_request(1'b0, make_addr(0, 5, 3), 32'ha5a5_a5a5, 4'b0101, EXP_HIT, '0);
        issue_request(1'b1, make_addr(0, 5, 3), '0, '0, EXP_HIT, '0);
        issue_request(1'b1, make_addr(1, 5, 0), '0, '0, EXP_MISS, '0);
        issue_request(1'b1, make_addr(0, 5, 6), '0, '0, EXP_HIT, '0);
        // tag 2 must push out tag 1
        issue_request(1'b1, make_addr(2, 5, 2), '0, '0, EXP_MISS, '0);
        issue_request(1'b1, make_addr(0, 5, 1), '0, '0, EXP_HIT, '0);
        issue_request(1'b1, make_addr(1, 5, 0), '0, '0, EXP_MISS, '0);
        // dirty tag 0 goes back to memory
        issue_request(1'b1, make_addr(2, 5, 2), '0, '0, EXP_WB, make_addr(0, 5, 0));
        issue_request(1'b1, make_addr(0, 5, 3), '0, '0, EXP_MISS, '0);

        // partial write that misses
        issue_request(1'b0, make_addr(3, 9, 6), 32'h1234_5678, 4'b1001, EXP_MISS, '0);
        issue_request(1'b1, make_addr(3, 9, 6), '0, '0, EXP_HIT, '0);

        // three tags rotate through set 20 and from the third write on each evicts a dirty line
        for (int i = 0; i < 12; i++) begin
            issue_request(1'b0, make_addr(i % 3, 20, i % 8),
                          32'hdead_beef ^ (i * 32'h0101_0101), wsel_t'(i + 1),
                          (i < 2) ? EXP_MISS : EXP_WB,
                          (i < 2) ? addr_t'(0) : make_addr((i + 1) % 3, 20, 0));
            issue_request(1'b1, make_addr(i % 3, 20, i % 8), '0, '0, EXP_HIT, '0);
        end

        wait_idle();
        @(posedge clk);
        #1;
        $display("Testbench passed");
        $finish;
    end

endmodule
